//--- Makefile
SIM := obj_dir/rv64_decoder_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
		--top-module rv64_decoder_tb -o rv64_decoder_sim

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- build.f
+incdir+verilog
+incdir+tests
verilog/decoder_pkg.sv
verilog/field_decode_stage.sv
verilog/control_decode_stage.sv
verilog/rv64_decoder.sv
tests/rv64_decoder_tb.sv

//--- tests/decoder_model.svh
`ifndef DECODER_MODEL_SVH
`define DECODER_MODEL_SVH

// one-hot alu op for an RV64I funct3, alt picks sub or sra
function automatic alu_type_t alu_op_of(input logic [2:0] f3, input logic alt);
    alu_type_t a;
    a = '0;
    case (f3)
        3'd0:       a[alt ? ALU_SUB : ALU_ADD] = 1'b1;
        3'd1:       a[ALU_SLL] = 1'b1;
        3'd2, 3'd3: a[ALU_SLT] = 1'b1;
        3'd4:       a[ALU_XOR] = 1'b1;
        3'd5:       a[alt ? ALU_SRA : ALU_SRL] = 1'b1;
        3'd6:       a[ALU_OR] = 1'b1;
        default:    a[ALU_AND] = 1'b1;
    endcase
    return a;
endfunction

function automatic uop_t expected_uop(input logic valid, input instr_t ins, input pc_t pc);
    uop_t u;
    logic ok;
    logic wb;
    logic alt_ok;
    logic [2:0] f3;
    logic [6:0] f7;
    u = '0;
    ok = 1'b1;
    wb = 1'b1;
    f3 = ins[14:12];
    f7 = ins[31:25];
    alt_ok = (f7 == 7'b0000000) || (f7 == 7'b0100000);
    case (ins[6:0])
        7'b0110111: begin
            u.imm = xlen_t'($signed({ins[31:12], 12'h000}));
            u.alu_type[ALU_LUI] = 1'b1;
        end
        7'b0010111: begin
            u.imm = xlen_t'($signed({ins[31:12], 12'h000}));
            u.alu_type[ALU_AUIPC] = 1'b1;
        end
        7'b1101111: begin
            u.imm = xlen_t'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
            u.cx_type[CX_JAL] = 1'b1;
        end
        7'b1100111: begin
            u.imm = xlen_t'($signed(ins[31:20]));
            u.cx_type[CX_JALR] = 1'b1;
            u.src1_is_reg = 1'b1;
        end
        7'b1100011: begin
            u.imm = xlen_t'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
            wb = 1'b0;
            u.src1_is_reg = 1'b1;
            u.src2_is_reg = 1'b1;
            u.is_unsigned = f3[1];
            case (f3)
                3'd0:       u.cx_type[CX_BEQ] = 1'b1;
                3'd1:       u.cx_type[CX_BNE] = 1'b1;
                3'd4, 3'd6: u.cx_type[CX_BLT] = 1'b1;
                3'd5, 3'd7: u.cx_type[CX_BGE] = 1'b1;
                default:    ok = 1'b0;
            endcase
        end
        7'b0000011: begin
            u.imm = xlen_t'($signed(ins[31:20]));
            u.is_load = 1'b1;
            u.src1_is_reg = 1'b1;
            u.is_unsigned = f3[2];
            u.ls_size[f3[1:0]] = 1'b1;
            ok = (f3 != 3'd7);
        end
        7'b0100011: begin
            u.imm = xlen_t'($signed({ins[31:25], ins[11:7]}));
            wb = 1'b0;
            u.is_store = 1'b1;
            u.src1_is_reg = 1'b1;
            u.src2_is_reg = 1'b1;
            u.ls_size[f3[1:0]] = 1'b1;
            ok = !f3[2];
        end
        7'b0010011: begin
            u.imm = xlen_t'($signed(ins[31:20]));
            u.is_imm = 1'b1;
            u.src1_is_reg = 1'b1;
            u.is_unsigned = (f3 == 3'd3);
            u.alu_type = alu_op_of(f3, (f3 == 3'd5) && f7[5]);
            // shamt is six bits wide
            if (f3 == 3'd1) begin
                ok = (f7[6:1] == 6'd0);
            end else if (f3 == 3'd5) begin
                ok = (f7[6:1] == 6'd0) || (f7[6:1] == 6'b010000);
            end
        end
        7'b0110011: begin
            u.src1_is_reg = 1'b1;
            u.src2_is_reg = 1'b1;
            u.is_unsigned = (f3 == 3'd3);
            u.alu_type = alu_op_of(f3, f7[5]);
            ok = (f7 == 7'd0) || ((f7 == 7'b0100000) && (f3 == 3'd0 || f3 == 3'd5));
        end
        7'b0011011: begin
            u.imm = xlen_t'($signed(ins[31:20]));
            u.is_imm = 1'b1;
            u.is_word = 1'b1;
            u.src1_is_reg = 1'b1;
            u.alu_type = alu_op_of(f3, (f3 == 3'd5) && f7[5]);
            ok = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'd0) || (f3 == 3'd5 && alt_ok);
        end
        7'b0111011: begin
            u.is_word = 1'b1;
            u.src1_is_reg = 1'b1;
            u.src2_is_reg = 1'b1;
            u.alu_type = alu_op_of(f3, f7[5]);
            ok = (f3 == 3'd1 && f7 == 7'd0) || ((f3 == 3'd0 || f3 == 3'd5) && alt_ok);
        end
        default: begin
            ok = 1'b0;
        end
    endcase
    u.need_to_wb = wb && (ins[11:7] != 5'd0);
    if (!ok) begin
        u = '0;
    end
    u.valid = valid;
    u.pc = pc;
    u.rs1 = ins[19:15];
    u.rs2 = ins[24:20];
    u.rd = ins[11:7];
    return u;
endfunction

`endif

//--- tests/rv64_decoder_tb.sv
`default_nettype none

module rv64_decoder_tb
    import decoder_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    `include "decoder_model.svh"

    localparam int N_IDLE = 40;
    localparam int N_IMM = 300;
    localparam int N_ALU = 300;
    localparam int N_CTRL = 300;
    localparam int N_X0 = 100;
    localparam int N_BAD = 200;
    // reset, every test, two drain cycles per test
    localparam int TOTAL_CYCLES = 4 + N_IDLE + N_IMM + N_ALU + N_CTRL + 2 * N_X0 + N_BAD + 12;

    logic   clk;
    logic   arst_n;
    logic   instr_valid;
    instr_t instr;
    pc_t    pc;
    uop_t   uop;

    uop_t  want_q[$];
    bit    full_q[$];
    string cur_test;
    int    test_checks;
    int    test_errors;
    int    total_checks;
    int    total_errors;

    rv64_decoder u_rv64_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .uop         (uop)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #((TOTAL_CYCLES + 200) * 100);
        $display("watchdog expired before all tests finished");
        $display("test failed");
        $finish;
    end

    function automatic logic [6:0] unknown_opcode();
        logic [6:0] op;
        op = 7'($urandom);
        while (op inside {7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
                          7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011, 7'b0011011,
                          7'b0111011}) begin
            op = 7'($urandom);
        end
        return op;
    endfunction

    function automatic logic [2:0] word_funct3();
        case ($urandom_range(0, 2))
            0:       return 3'd0;
            1:       return 3'd1;
            default: return 3'd5;
        endcase
    endfunction

    // kinds 0..10 follow the opcode classes lui .. alu_reg_word
    function automatic instr_t valid_encoding(input int kind);
        instr_t w;
        logic [2:0] f3;
        w = $urandom;
        f3 = w[14:12];
        case (kind)
            0: w[6:0] = 7'b0110111;
            1: w[6:0] = 7'b0010111;
            2: w[6:0] = 7'b1101111;
            3: begin
                w[6:0] = 7'b1100111;
                w[14:12] = 3'd0;
            end
            4: begin
                w[6:0] = 7'b1100011;
                // funct3 2 and 3 fold onto beq and bne
                if (f3[2:1] == 2'b01) begin
                    w[13] = 1'b0;
                end
            end
            5: begin
                w[6:0] = 7'b0000011;
                w[14:12] = 3'($urandom_range(0, 6));
            end
            6: begin
                w[6:0] = 7'b0100011;
                w[14] = 1'b0;
            end
            7: begin
                w[6:0] = 7'b0010011;
                if (f3 == 3'd1) begin
                    w[31:26] = 6'd0;
                end else if (f3 == 3'd5) begin
                    w[31:26] = w[30] ? 6'b010000 : 6'b000000;
                end
            end
            8: begin
                w[6:0] = 7'b0110011;
                w[31:25] = (w[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'd0;
            end
            9: begin
                w[6:0] = 7'b0011011;
                f3 = word_funct3();
                w[14:12] = f3;
                if (f3 != 3'd0) begin
                    w[31:25] = (w[30] && f3 == 3'd5) ? 7'b0100000 : 7'd0;
                end
            end
            default: begin
                w[6:0] = 7'b0111011;
                f3 = word_funct3();
                w[14:12] = f3;
                w[31:25] = (w[30] && f3 != 3'd1) ? 7'b0100000 : 7'd0;
            end
        endcase
        return w;
    endfunction

    function automatic instr_t bad_encoding();
        instr_t w;
        w = $urandom;
        case ($urandom_range(0, 6))
            0: w[6:0] = unknown_opcode();
            1: begin
                // multiply and divide
                w[6:0] = w[3] ? 7'b0110011 : 7'b0111011;
                w[31:25] = 7'b0000001;
            end
            2: begin
                w[6:0] = 7'b1100011;
                w[14:13] = 2'b01;
            end
            3: begin
                w[6:0] = 7'b0000011;
                w[14:12] = 3'd7;
            end
            4: begin
                w[6:0] = 7'b0100011;
                w[14] = 1'b1;
            end
            5: begin
                w[6:0] = 7'b0010011;
                w[13:12] = 2'b01;
                w[31] = 1'b1;
            end
            default: begin
                w[6:0] = 7'b0111011;
                w[31:25] = 7'b0100000;
                w[14:12] = w[12] ? 3'd1 : 3'd4;
            end
        endcase
        return w;
    endfunction

    task automatic check_valid_low();
        test_checks++;
        assert (uop.valid === 1'b0) else begin
            test_errors++;
            $display("CHECK FAILED %s expected valid 0 actual %b", cur_test, uop.valid);
        end
    endtask

    task automatic check_output();
        uop_t want;
        bit   full;
        want = want_q.pop_front();
        full = full_q.pop_front();
        if (!full) begin
            check_valid_low();
        end else begin
            test_checks++;
            assert (uop === want) else begin
                test_errors++;
                $display("CHECK FAILED %s expected %h actual %h", cur_test, want, uop);
            end
            if (want.valid && want.rd == 5'd0) begin
                test_checks++;
                assert (uop.need_to_wb === 1'b0) else begin
                    test_errors++;
                    $display("CHECK FAILED %s need_to_wb for x0 expected 0 actual %b",
                             cur_test, uop.need_to_wb);
                end
            end
        end
    endtask

    task automatic run_cycle(input logic v, input instr_t w);
        pc_t p;
        p = pc_t'({$urandom, $urandom});
        @(posedge clk);
        #5;
        check_output();
        instr_valid = v;
        instr = w;
        pc = p;
        want_q.push_back(expected_uop(v, w, p));
        full_q.push_back(1'b1);
    endtask

    // upper kinds of the range are drawn more often
    task automatic run_block(input int n, input int lo, input int hi, input int bad_in_8,
                             input bit idle);
        int k;
        instr_t w;
        for (int i = 0; i < n; i++) begin
            k = $urandom_range(lo, hi + 3);
            if (k > hi) begin
                k = 2 * hi + 1 - k;
            end
            w = ($urandom_range(0, 7) < bad_in_8) ? bad_encoding() : valid_encoding(k);
            run_cycle(!(idle && $urandom_range(0, 4) == 0), w);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        repeat (2) begin
            run_cycle(1'b0, $urandom);
        end
        $display("%-12s checks %4d  errors %0d", cur_test, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    initial begin
        instr_t w;
        void'($urandom(32'h6a4a_be65));
        arst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        total_checks = 0;
        total_errors = 0;

        start_test("reset_idle");
        repeat (4) begin
            @(posedge clk);
            #5;
            check_valid_low();
        end
        arst_n = 1'b1;
        // payload is unknown until the pipe fills
        repeat (2) begin
            want_q.push_back('0);
            full_q.push_back(1'b0);
        end
        run_block(16, 0, 10, 1, 1'b0);
        for (int i = 0; i < N_IDLE - 16; i++) begin
            run_cycle(i % 3 != 0, valid_encoding($urandom_range(0, 10)));
        end
        finish_test();

        start_test("immediates");
        run_block(N_IMM, 0, 10, 0, 1'b1);
        finish_test();

        start_test("alu_ops");
        run_block(N_ALU, 7, 10, 0, 1'b1);
        finish_test();

        start_test("branch_mem");
        run_block(N_CTRL, 2, 6, 0, 1'b1);
        finish_test();

        start_test("rd_x0");
        for (int i = 0; i < N_X0; i++) begin
            w = valid_encoding($urandom_range(0, 10));
            w[11:7] = 5'd0;
            run_cycle(1'b1, w);
            w[11:7] = 5'($urandom_range(1, 31));
            run_cycle(1'b1, w);
        end
        finish_test();

        start_test("unsupported");
        run_block(N_BAD, 0, 10, 8, 1'b1);
        finish_test();

        $display("%0d checks passed, %0d failed", total_checks - total_errors, total_errors);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/control_decode_stage.sv
`default_nettype none

module control_decode_stage
    import decoder_pkg::*;
(
    input  wire          clk,
    input  wire          arst_n,
    input  wire fields_t fields,
    output uop_t         uop
);

    uop_t uop_d;
    logic supported;
    logic writes_rd;

    always_comb begin
        uop_d     = '0;
        supported = 1'b1;
        writes_rd = 1'b1;

        case (fields.op_class)
            OP_LUI: begin
                uop_d.alu_type[ALU_LUI] = 1'b1;
            end
            OP_AUIPC: begin
                uop_d.alu_type[ALU_AUIPC] = 1'b1;
            end
            OP_JAL: begin
                uop_d.cx_type[CX_JAL] = 1'b1;
            end
            OP_JALR: begin
                uop_d.cx_type[CX_JALR] = 1'b1;
                uop_d.src1_is_reg      = 1'b1;
            end
            OP_BRANCH: begin
                writes_rd         = 1'b0;
                uop_d.src1_is_reg = 1'b1;
                uop_d.src2_is_reg = 1'b1;
                // bit 1 of funct3 selects the unsigned compare
                uop_d.is_unsigned = fields.funct3[1];
                case (fields.funct3)
                    3'b000:         uop_d.cx_type[CX_BEQ] = 1'b1;
                    3'b001:         uop_d.cx_type[CX_BNE] = 1'b1;
                    3'b100, 3'b110: uop_d.cx_type[CX_BLT] = 1'b1;
                    3'b101, 3'b111: uop_d.cx_type[CX_BGE] = 1'b1;
                    default:        supported = 1'b0;
                endcase
            end
            OP_LOAD: begin
                uop_d.is_load     = 1'b1;
                uop_d.src1_is_reg = 1'b1;
                uop_d.is_unsigned = fields.funct3[2];
                case (fields.funct3)
                    3'b000, 3'b100: uop_d.ls_size[LS_BYTE]   = 1'b1;
                    3'b001, 3'b101: uop_d.ls_size[LS_HALF]   = 1'b1;
                    3'b010, 3'b110: uop_d.ls_size[LS_WORD]   = 1'b1;
                    3'b011:         uop_d.ls_size[LS_DOUBLE] = 1'b1;
                    default:        supported = 1'b0;
                endcase
            end
            OP_STORE: begin
                writes_rd         = 1'b0;
                uop_d.is_store    = 1'b1;
                uop_d.src1_is_reg = 1'b1;
                uop_d.src2_is_reg = 1'b1;
                case (fields.funct3)
                    3'b000:  uop_d.ls_size[LS_BYTE]   = 1'b1;
                    3'b001:  uop_d.ls_size[LS_HALF]   = 1'b1;
                    3'b010:  uop_d.ls_size[LS_WORD]   = 1'b1;
                    3'b011:  uop_d.ls_size[LS_DOUBLE] = 1'b1;
                    default: supported = 1'b0;
                endcase
            end
            OP_ALU_IMM: begin
                uop_d.is_imm      = 1'b1;
                uop_d.src1_is_reg = 1'b1;
                case (fields.funct3)
                    3'b000: uop_d.alu_type[ALU_ADD] = 1'b1;
                    3'b010: uop_d.alu_type[ALU_SLT] = 1'b1;
                    3'b011: begin
                        uop_d.alu_type[ALU_SLT] = 1'b1;
                        uop_d.is_unsigned       = 1'b1;
                    end
                    3'b100: uop_d.alu_type[ALU_XOR] = 1'b1;
                    3'b110: uop_d.alu_type[ALU_OR]  = 1'b1;
                    3'b111: uop_d.alu_type[ALU_AND] = 1'b1;
                    // funct7[0] is shamt[5] here
                    3'b001: begin
                        if (fields.funct7[6:1] == 6'b000000) begin
                            uop_d.alu_type[ALU_SLL] = 1'b1;
                        end else begin
                            supported = 1'b0;
                        end
                    end
                    default: begin
                        if (fields.funct7[6:1] == 6'b000000) begin
                            uop_d.alu_type[ALU_SRL] = 1'b1;
                        end else if (fields.funct7[6:1] == 6'b010000) begin
                            uop_d.alu_type[ALU_SRA] = 1'b1;
                        end else begin
                            supported = 1'b0;
                        end
                    end
                endcase
            end
            OP_ALU_REG: begin
                uop_d.src1_is_reg = 1'b1;
                uop_d.src2_is_reg = 1'b1;
                case ({fields.funct7, fields.funct3})
                    10'b0000000_000: uop_d.alu_type[ALU_ADD] = 1'b1;
                    10'b0100000_000: uop_d.alu_type[ALU_SUB] = 1'b1;
                    10'b0000000_001: uop_d.alu_type[ALU_SLL] = 1'b1;
                    10'b0000000_010: uop_d.alu_type[ALU_SLT] = 1'b1;
                    10'b0000000_011: begin
                        uop_d.alu_type[ALU_SLT] = 1'b1;
                        uop_d.is_unsigned       = 1'b1;
                    end
                    10'b0000000_100: uop_d.alu_type[ALU_XOR] = 1'b1;
                    10'b0000000_101: uop_d.alu_type[ALU_SRL] = 1'b1;
                    10'b0100000_101: uop_d.alu_type[ALU_SRA] = 1'b1;
                    10'b0000000_110: uop_d.alu_type[ALU_OR]  = 1'b1;
                    10'b0000000_111: uop_d.alu_type[ALU_AND] = 1'b1;
                    default:         supported = 1'b0;
                endcase
            end
            OP_ALU_IMM_WORD: begin
                uop_d.is_imm      = 1'b1;
                uop_d.is_word     = 1'b1;
                uop_d.src1_is_reg = 1'b1;
                // word shifts have a 5 bit shamt, so funct7 is exact
                if (fields.funct3 == 3'b000) begin
                    uop_d.alu_type[ALU_ADD] = 1'b1;
                end else begin
                    case ({fields.funct7, fields.funct3})
                        10'b0000000_001: uop_d.alu_type[ALU_SLL] = 1'b1;
                        10'b0000000_101: uop_d.alu_type[ALU_SRL] = 1'b1;
                        10'b0100000_101: uop_d.alu_type[ALU_SRA] = 1'b1;
                        default:         supported = 1'b0;
                    endcase
                end
            end
            OP_ALU_REG_WORD: begin
                uop_d.is_word     = 1'b1;
                uop_d.src1_is_reg = 1'b1;
                uop_d.src2_is_reg = 1'b1;
                case ({fields.funct7, fields.funct3})
                    10'b0000000_000: uop_d.alu_type[ALU_ADD] = 1'b1;
                    10'b0100000_000: uop_d.alu_type[ALU_SUB] = 1'b1;
                    10'b0000000_001: uop_d.alu_type[ALU_SLL] = 1'b1;
                    10'b0000000_101: uop_d.alu_type[ALU_SRL] = 1'b1;
                    10'b0100000_101: uop_d.alu_type[ALU_SRA] = 1'b1;
                    default:         supported = 1'b0;
                endcase
            end
            default: begin
                supported = 1'b0;
            end
        endcase

        // x0 is never written back
        uop_d.need_to_wb = writes_rd && (fields.rd != '0);
        uop_d.imm        = fields.imm;

        if (!supported) begin
            uop_d = '0;
        end

        uop_d.valid = fields.valid;
        uop_d.pc    = fields.pc;
        uop_d.rs1   = fields.rs1;
        uop_d.rs2   = fields.rs2;
        uop_d.rd    = fields.rd;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            uop.valid <= 1'b0;
        end else begin
            uop <= uop_d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/decoder_pkg.sv
`default_nettype none

`include "decoder_settings.svh"

package decoder_pkg;

    typedef logic [`INSTR_W-1:0]   instr_t;
    typedef logic [`XLEN-1:0]      xlen_t;
    typedef logic [`PC_W-1:0]      pc_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // opcode classes seen by the second stage
    typedef enum logic [3:0] {
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_LOAD,
        OP_STORE,
        OP_ALU_IMM,
        OP_ALU_REG,
        OP_ALU_IMM_WORD,
        OP_ALU_REG_WORD,
        OP_UNSUPPORTED
    } op_class_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    // branch and jump kind, one hot
    typedef logic [5:0] cx_type_t;
    localparam int CX_JAL  = 0;
    localparam int CX_JALR = 1;
    localparam int CX_BEQ  = 2;
    localparam int CX_BNE  = 3;
    localparam int CX_BLT  = 4;
    localparam int CX_BGE  = 5;

    // alu operation, one hot
    typedef logic [10:0] alu_type_t;
    localparam int ALU_ADD   = 0;
    localparam int ALU_SUB   = 1;
    localparam int ALU_SLL   = 2;
    localparam int ALU_SLT   = 3;
    localparam int ALU_XOR   = 4;
    localparam int ALU_SRL   = 5;
    localparam int ALU_SRA   = 6;
    localparam int ALU_OR    = 7;
    localparam int ALU_AND   = 8;
    localparam int ALU_LUI   = 9;
    localparam int ALU_AUIPC = 10;

    // memory access size, one hot
    typedef logic [3:0] ls_size_t;
    localparam int LS_BYTE   = 0;
    localparam int LS_HALF   = 1;
    localparam int LS_WORD   = 2;
    localparam int LS_DOUBLE = 3;

    typedef struct packed {
        logic   valid;
        pc_t    pc;
        instr_t instr;
    } fetch_t;

    typedef struct packed {
        logic      valid;
        pc_t       pc;
        op_class_e op_class;
        logic [2:0] funct3;
        logic [6:0] funct7;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        xlen_t     imm;
    } fields_t;

    typedef struct packed {
        logic      valid;
        pc_t       pc;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        xlen_t     imm;
        logic      src1_is_reg;
        logic      src2_is_reg;
        logic      need_to_wb;
        cx_type_t  cx_type;
        alu_type_t alu_type;
        ls_size_t  ls_size;
        logic      is_unsigned;
        logic      is_word;
        logic      is_imm;
        logic      is_load;
        logic      is_store;
    } uop_t;

endpackage

`default_nettype wire

//--- verilog/decoder_settings.svh
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

// fetched instruction word
`define INSTR_W 32

// integer register and immediate width
`define XLEN 64

// virtual address bits carried with each instruction
`define PC_W 48

// architectural register number
`define REG_IDX_W 5

`endif

//--- verilog/field_decode_stage.sv
`default_nettype none

`include "decoder_settings.svh"

module field_decode_stage
    import decoder_pkg::*;
(
    input  wire         clk,
    input  wire         arst_n,
    input  wire fetch_t fetch,
    output fields_t     fields
);

    localparam logic [6:0] OPC_LUI           = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC         = 7'b0010111;
    localparam logic [6:0] OPC_JAL           = 7'b1101111;
    localparam logic [6:0] OPC_JALR          = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH        = 7'b1100011;
    localparam logic [6:0] OPC_LOAD          = 7'b0000011;
    localparam logic [6:0] OPC_STORE         = 7'b0100011;
    localparam logic [6:0] OPC_ALU_IMM       = 7'b0010011;
    localparam logic [6:0] OPC_ALU_REG       = 7'b0110011;
    localparam logic [6:0] OPC_ALU_IMM_WORD  = 7'b0011011;
    localparam logic [6:0] OPC_ALU_REG_WORD  = 7'b0111011;

    instr_t    instr;
    op_class_e op_class;
    imm_fmt_e  imm_fmt;
    xlen_t     imm;
    fields_t   fields_d;

    assign instr = fetch.instr;

    always_comb begin
        case (instr[6:0])
            OPC_LUI:          op_class = OP_LUI;
            OPC_AUIPC:        op_class = OP_AUIPC;
            OPC_JAL:          op_class = OP_JAL;
            OPC_JALR:         op_class = OP_JALR;
            OPC_BRANCH:       op_class = OP_BRANCH;
            OPC_LOAD:         op_class = OP_LOAD;
            OPC_STORE:        op_class = OP_STORE;
            OPC_ALU_IMM:      op_class = OP_ALU_IMM;
            OPC_ALU_REG:      op_class = OP_ALU_REG;
            OPC_ALU_IMM_WORD: op_class = OP_ALU_IMM_WORD;
            OPC_ALU_REG_WORD: op_class = OP_ALU_REG_WORD;
            default:          op_class = OP_UNSUPPORTED;
        endcase
    end

    always_comb begin
        case (op_class)
            OP_JALR, OP_LOAD, OP_ALU_IMM, OP_ALU_IMM_WORD: imm_fmt = IMM_I;
            OP_STORE:                                      imm_fmt = IMM_S;
            OP_BRANCH:                                     imm_fmt = IMM_B;
            OP_LUI, OP_AUIPC:                              imm_fmt = IMM_U;
            OP_JAL:                                        imm_fmt = IMM_J;
            default:                                       imm_fmt = IMM_NONE;
        endcase
    end

    // all formats sign extend from instr[31]
    always_comb begin
        case (imm_fmt)
            IMM_I: imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            IMM_S: imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B: imm = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                          instr[30:25], instr[11:8], 1'b0};
            IMM_U: imm = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
            IMM_J: imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                          instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        fields_d.valid    = fetch.valid;
        fields_d.pc       = fetch.pc;
        fields_d.op_class = op_class;
        fields_d.funct3   = instr[14:12];
        fields_d.funct7   = instr[31:25];
        fields_d.rs1      = instr[19:15];
        fields_d.rs2      = instr[24:20];
        fields_d.rd       = instr[11:7];
        fields_d.imm      = imm;
    end

    // payload loads every cycle, only valid sees reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fields.valid <= 1'b0;
        end else begin
            fields <= fields_d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv64_decoder.sv
`default_nettype none

module rv64_decoder
    import decoder_pkg::*;
(
    input  wire         clk,
    input  wire         arst_n,
    input  wire         instr_valid,
    input  wire instr_t instr,
    input  wire pc_t    pc,
    output uop_t        uop
);

    fetch_t  fetch;
    fields_t fields;

    assign fetch.valid = instr_valid;
    assign fetch.pc    = pc;
    assign fetch.instr = instr;

    // opcode class, register fields and immediate
    field_decode_stage u_field (
        .clk    (clk),
        .arst_n (arst_n),
        .fetch  (fetch),
        .fields (fields)
    );

    // funct decode into control groups
    control_decode_stage u_control (
        .clk    (clk),
        .arst_n (arst_n),
        .fields (fields),
        .uop    (uop)
    );

endmodule

`default_nettype wire
